// File: rtl/wb_pkg.sv
package wb_pkg;

   // --------------------------------------------------
   // Bus geometry
   // --------------------------------------------------

   localparam int WB_DATA_W = 16;        // Bus data word
   localparam int WB_ADR_W  = 6;         // Word address, 64 words

   // --------------------------------------------------
   // On-chip memory slave
   // --------------------------------------------------

   localparam int SRAM_WORDS   = 64;     // Memory depth in words
   localparam int SRAM_LATENCY = 2;      // Accepted strobe to ack, in cycles

   // --------------------------------------------------
   // Burst master request tracking
   // --------------------------------------------------

   // Outstanding request counter width
   // Room for SRAM_LATENCY plus one requests in flight
   localparam int QUEUE_BITS = 2;

endpackage

// File: rtl/blk_pkg.sv
package blk_pkg;

   // --------------------------------------------------
   // Block geometry
   // --------------------------------------------------

   localparam int BLK_WORDS = 8;         // Words per block
   localparam int BLK_OFS_W = 3;         // Offset inside a block
   localparam int BLK_IDX_W = 3;         // Block number

   // --------------------------------------------------
   // Command encoding
   // --------------------------------------------------

   // Reduction select, top command bit
   localparam logic OP_SUM = 1'b0;       // Modulo 2^16 sum
   localparam logic OP_XOR = 1'b1;       // Bitwise XOR

   // {op, block index}
   localparam int CMD_W = 4;

endpackage

// File: rtl/fetch_decode.sv
`timescale 1ns/100ps

module fetch_decode
   import wb_pkg::*, blk_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                cmd_valid_i,
   input  logic [CMD_W-1:0]    cmd_i,
   input  logic                done_i,
   output logic                busy_o,
   output logic                fetch_start_o,
   output logic [WB_ADR_W-1:0] base_o,
   output logic                op_o
);

   logic [BLK_IDX_W-1:0] idx_q;          // Latched block number
   logic                 op_q;
   logic                 accept;

   // Commands while busy are dropped
   assign accept = cmd_valid_i && !busy_o;

   // --------------------------------------------------
   // Busy flag and fetch start pulse
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_o        <= 1'b0;
         fetch_start_o <= 1'b0;
      end else begin
         fetch_start_o <= accept;        // One cycle after acceptance
         if (accept)
            busy_o <= 1'b1;
         else if (done_i)
            busy_o <= 1'b0;              // Falls the cycle after done
      end
   end

   // Command fields, held for the whole burst
   always_ff @(posedge clk_i) begin
      if (accept) begin
         op_q  <= cmd_i[CMD_W-1];
         idx_q <= cmd_i[BLK_IDX_W-1:0];
      end
   end

   assign op_o   = op_q;
   assign base_o = WB_ADR_W'(int'(idx_q) * BLK_WORDS);  // First word of block

endmodule

// File: rtl/fetch_burst.sv
`timescale 1ns/100ps

module fetch_burst
   import wb_pkg::*, blk_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                fetch_i,
   input  logic [WB_ADR_W-1:0] base_i,
   input  logic                ack_i,
   input  logic                stall_i,
   output logic                cyc_o,
   output logic                stb_o,
   output logic [WB_ADR_W-1:0] adr_o,
   output logic                ready_o
);

   logic [BLK_OFS_W-1:0]  ofs_q;         // Word offset of the current strobe
   logic [QUEUE_BITS-1:0] out_cnt;       // Requests issued but not yet acked
   logic                  accept;
   logic                  ofs_last;
   logic                  last_ack;

   // --------------------------------------------------
   // Handshake decode
   // --------------------------------------------------

   assign accept   = stb_o && !stall_i;                     // Strobe taken by slave
   assign ofs_last = ofs_q == BLK_OFS_W'(BLK_WORDS - 1);

   // All strobes out and the only pending request returns
   assign last_ack = ack_i && !stb_o && out_cnt == QUEUE_BITS'(1);

   assign adr_o = base_i + WB_ADR_W'(ofs_q);

   // --------------------------------------------------
   // Bus cycle and strobe
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cyc_o <= 1'b0;
         stb_o <= 1'b0;
      end else if (fetch_i) begin
         cyc_o <= 1'b1;
         stb_o <= 1'b1;
      end else if (cyc_o) begin
         cyc_o <= !last_ack;
         stb_o <= stb_o && !(accept && ofs_last);  // Held while stalled
      end
   end

   // Offset counter
   // Advances only on accepted strobes, so the address holds under stall
   always_ff @(posedge clk_i) begin
      if (rst_i || fetch_i)
         ofs_q <= '0;
      else if (accept && !ofs_last)
         ofs_q <= ofs_q + 1'b1;
   end

   // --------------------------------------------------
   // Outstanding request counter
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i || fetch_i) begin
         out_cnt <= '0;                  // Empty at burst start
      end else begin
         case ({accept, ack_i})
            2'b10:   out_cnt <= out_cnt + 1'b1;   // New request
            2'b01:   out_cnt <= out_cnt - 1'b1;   // Data back
            default: out_cnt <= out_cnt;          // Issue and return cancel out
         endcase
      end
   end

   // Burst done, one cycle after the final ack
   always_ff @(posedge clk_i) begin
      if (rst_i)
         ready_o <= 1'b0;
      else
         ready_o <= cyc_o && last_ack;
   end

endmodule

// File: rtl/wb_sram.sv
`timescale 1ns/100ps

module wb_sram
   import wb_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 cyc_i,
   input  logic                 stb_i,
   input  logic [WB_ADR_W-1:0]  adr_i,
   input  logic                 stall_i,
   input  logic                 load_we_i,
   input  logic [WB_ADR_W-1:0]  load_adr_i,
   input  logic [WB_DATA_W-1:0] load_dat_i,
   output logic                 ack_o,
   output logic                 stall_o,
   output logic [WB_DATA_W-1:0] dat_o
);

   logic [WB_DATA_W-1:0] mem [SRAM_WORDS];

   // Delay line, one entry per cycle of latency
   logic                 vld_q [SRAM_LATENCY];
   logic [WB_DATA_W-1:0] dat_q [SRAM_LATENCY];
   logic                 accept;

   assign accept  = cyc_i && stb_i && !stall_i;
   assign stall_o = stall_i;             // Back-pressure comes from outside

   // --------------------------------------------------
   // Load port
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (load_we_i)
         mem[load_adr_i] <= load_dat_i;
   end

   // --------------------------------------------------
   // Read pipeline
   // --------------------------------------------------
   // Valid bit and read data shift one stage per cycle toward ack_o
   always_ff @(posedge clk_i) begin
      vld_q[0] <= accept;
      if (accept)
         dat_q[0] <= mem[adr_i];         // Synchronous read
      for (int i = 1; i < SRAM_LATENCY; i++) begin
         vld_q[i] <= vld_q[i-1];
         dat_q[i] <= dat_q[i-1];
      end
   end

   // Ack exactly SRAM_LATENCY cycles after acceptance
   assign ack_o = vld_q[SRAM_LATENCY-1];
   assign dat_o = dat_q[SRAM_LATENCY-1];

endmodule

// File: rtl/fetch_result.sv
`timescale 1ns/100ps

module fetch_result
   import wb_pkg::*, blk_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 clear_i,
   input  logic                 op_i,
   input  logic                 cyc_i,
   input  logic                 ack_i,
   input  logic [WB_DATA_W-1:0] dat_i,
   input  logic                 ready_i,
   output logic                 done_o,
   output logic [WB_DATA_W-1:0] result_o
);

   logic [WB_DATA_W-1:0] acc_q;          // Running reduction

   // --------------------------------------------------
   // Accumulator
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (clear_i) begin
         acc_q <= '0;                    // Fresh block
      end else if (cyc_i && ack_i) begin
         case (op_i)
            OP_SUM:  acc_q <= acc_q + dat_i;    // Wraps mod 2^16
            OP_XOR:  acc_q <= acc_q ^ dat_i;
            default: acc_q <= acc_q;
         endcase
      end
   end

   // Result register and done pulse
   always_ff @(posedge clk_i) begin
      if (rst_i)
         done_o <= 1'b0;
      else
         done_o <= ready_i;
   end

   always_ff @(posedge clk_i) begin
      if (ready_i)
         result_o <= acc_q;
   end

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/100ps

module fetch_top
   import wb_pkg::*, blk_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 cmd_valid_i,
   input  logic [CMD_W-1:0]     cmd_i,
   input  logic                 load_we_i,
   input  logic [WB_ADR_W-1:0]  load_adr_i,
   input  logic [WB_DATA_W-1:0] load_dat_i,
   input  logic                 stall_i,
   output logic                 busy_o,
   output logic                 done_o,
   output logic [WB_DATA_W-1:0] result_o
);

   // --------------------------------------------------
   // Decode to execute
   // --------------------------------------------------
   logic                 fetch_start;
   logic                 fetch_ready;
   logic [WB_ADR_W-1:0]  blk_base;
   logic                 blk_op;

   // Wishbone
   logic                 wb_cyc, wb_stb, wb_ack, wb_stall;
   logic [WB_ADR_W-1:0]  wb_adr;
   logic [WB_DATA_W-1:0] wb_dat;

   fetch_decode decode_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i),
      .done_i(done_o),                   // Result pulse ends the busy period
      .busy_o(busy_o), .fetch_start_o(fetch_start),
      .base_o(blk_base), .op_o(blk_op)
   );

   fetch_burst burst_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .fetch_i(fetch_start), .base_i(blk_base),
      .ack_i(wb_ack), .stall_i(wb_stall),
      .cyc_o(wb_cyc), .stb_o(wb_stb), .adr_o(wb_adr),
      .ready_o(fetch_ready)
   );

   wb_sram sram_i (
      .clk_i(clk_i),
      .cyc_i(wb_cyc), .stb_i(wb_stb), .adr_i(wb_adr), .stall_i(stall_i),
      .load_we_i(load_we_i), .load_adr_i(load_adr_i), .load_dat_i(load_dat_i),
      .ack_o(wb_ack), .stall_o(wb_stall), .dat_o(wb_dat)
   );

   fetch_result result_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .clear_i(fetch_start), .op_i(blk_op),
      .cyc_i(wb_cyc), .ack_i(wb_ack), .dat_i(wb_dat),
      .ready_i(fetch_ready),
      .done_o(done_o), .result_o(result_o)
   );

endmodule

// File: tb/fetch_assertions.sv
`timescale 1ns/100ps

module fetch_assertions
   import wb_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  logic [WB_ADR_W-1:0]   adr_i,
   input  logic                  stall_i,
   input  logic                  ack_i,
   input  logic                  accept_i,     // Strobe taken this cycle
   input  logic [QUEUE_BITS-1:0] cnt_i         // Outstanding requests
);

   int fail_cnt = 0;                           // Read by the testbench at the end

   // Strobe only inside a bus cycle
   stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
      else begin
         $error("wb_stb high while wb_cyc is low");
         fail_cnt++;
      end

   // Master holds the request while the slave stalls
   stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && stall_i |=> stb_i && $stable(adr_i))
      else begin
         $error("wb_stb or wb_adr changed under stall");
         fail_cnt++;
      end

   // --------------------------------------------------
   // Outstanding counter range
   // --------------------------------------------------
   cnt_no_wrap_up: assert property (@(posedge clk_i) disable iff (rst_i)
      accept_i && !ack_i |-> cnt_i != '1)
      else begin
         $error("outstanding request count overflows");
         fail_cnt++;
      end

   cnt_no_wrap_down: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_i && !accept_i |-> cnt_i != '0)
      else begin
         $error("ack with no request outstanding");
         fail_cnt++;
      end

endmodule

// File: tb/fetch_checker.sv
`timescale 1ns/100ps

module fetch_checker
   import wb_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 cmd_valid_i,
   input  logic                 busy_i,
   input  logic                 done_i,
   input  logic [WB_DATA_W-1:0] result_i,
   input  logic                 exp_push_i,    // New expected result
   input  logic [WB_DATA_W-1:0] exp_val_i,
   input  logic [7:0]           exp_lat_i,     // Zero when latency is not checked
   output int                   err_cnt_o,
   output int                   chk_cnt_o,
   output int                   pend_o
);

   logic [WB_DATA_W-1:0] exp_q [$];           // Results still to come, in order
   logic [7:0]           lat_q [$];
   logic [WB_DATA_W-1:0] want_val;
   logic [7:0]           want_lat;
   logic                 started = 1'b0;      // First command seen
   int                   cyc_cnt = 0;
   int                   acc_cyc = 0;         // Edge of the last accepted command
   int                   lat;

   // Samples at the rising edge, inputs move on the falling edge
   always @(posedge clk_i) begin
      cyc_cnt++;
      if (rst_i) begin
         started   = 1'b0;
         err_cnt_o = 0;
         chk_cnt_o = 0;
         exp_q.delete();
         lat_q.delete();
      end else begin
         if (exp_push_i) begin
            exp_q.push_back(exp_val_i);
            lat_q.push_back(exp_lat_i);
         end

         // Quiet until the first command
         if (!started && (busy_i || done_i)) begin
            $display("ERR %0t: busy_o or done_o high before the first command", $time);
            err_cnt_o++;
         end

         if (cmd_valid_i && !busy_i) begin     // Same accept rule as decode
            started = 1'b1;
            acc_cyc = cyc_cnt;
         end

         // --------------------------------------------------
         // Result compare
         // --------------------------------------------------
         if (done_i) begin
            if (exp_q.size() == 0) begin
               $display("extra done_o at %0t with no command outstanding", $time);
               err_cnt_o++;
            end else begin
               want_val = exp_q.pop_front();
               want_lat = lat_q.pop_front();
               lat      = cyc_cnt - acc_cyc;      // Edges from accept to done_o seen
               chk_cnt_o++;
               if (result_i !== want_val) begin
                  $display("ERR %0t: result %h, expected %h", $time, result_i, want_val);
                  err_cnt_o++;
               end
               if (want_lat != 8'd0 && lat != int'(want_lat)) begin
                  $display("ERR %0t: done_o %0d cycles after accept, expected %0d",
                           $time, lat, want_lat);
                  err_cnt_o++;
               end
            end
         end
      end
      pend_o = exp_q.size();
   end

endmodule

// File: tb/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb
   import wb_pkg::*, blk_pkg::*;
();

   localparam int RST_CYCLES   = 10;
   localparam int CMD_BUDGET   = 40 * 4;       // Per command, worst stall density
   localparam int NO_STALL_LAT = BLK_WORDS + SRAM_LATENCY + 3;   // Accept to done_o

   logic                 clk_i, rst_i;
   logic                 cmd_valid, load_we, stall;
   logic [CMD_W-1:0]     cmd;
   logic [WB_ADR_W-1:0]  load_adr;
   logic [WB_DATA_W-1:0] load_dat;
   logic                 busy, done;
   logic [WB_DATA_W-1:0] result;

   // Checker side
   logic                 exp_push;
   logic [WB_DATA_W-1:0] exp_val;
   logic [7:0]           exp_lat;
   int                   chk_err, chk_cnt, pend;

   // Parsed stimulus
   logic [WB_ADR_W-1:0]  ld_adr [$];
   logic [WB_DATA_W-1:0] ld_dat [$];
   logic                 cmd_op [$];
   logic [BLK_IDX_W-1:0] cmd_idx [$];
   logic [1:0]           cmd_den [$];
   logic [WB_DATA_W-1:0] cmd_exp [$];

   logic [31:0]          lfsr   = 32'h9cff;
   int                   cycles = 0;
   int                   limit  = 0;       // Zero until the file is read

   fetch_top fetch_top_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .cmd_valid_i(cmd_valid), .cmd_i(cmd),
      .load_we_i(load_we), .load_adr_i(load_adr), .load_dat_i(load_dat),
      .stall_i(stall),
      .busy_o(busy), .done_o(done), .result_o(result)
   );

   fetch_checker checker_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .cmd_valid_i(cmd_valid), .busy_i(busy), .done_i(done), .result_i(result),
      .exp_push_i(exp_push), .exp_val_i(exp_val), .exp_lat_i(exp_lat),
      .err_cnt_o(chk_err), .chk_cnt_o(chk_cnt), .pend_o(pend)
   );

   bind fetch_burst fetch_assertions assertions_i (
      .clk_i(clk_i), .rst_i(rst_i), .cyc_i(cyc_o), .stb_i(stb_o), .adr_i(adr_o),
      .stall_i(stall_i), .ack_i(ack_i), .accept_i(accept), .cnt_i(out_cnt)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;               // 8 ns period
   end

   // Galois LFSR step
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   // Two fresh bits against the density, 0 never stalls
   task automatic draw_stall(input logic [1:0] den);
      logic [1:0] r;
      lfsr  = lfsr_step(lfsr);
      r[1]  = lfsr[0];
      lfsr  = lfsr_step(lfsr);
      r[0]  = lfsr[0];
      stall = r < den;
   endtask

   // --------------------------------------------------
   // Stimulus file
   // --------------------------------------------------
   task automatic read_stimulus();
      int                   fd, n, idx, op, den;
      string                tok, rest;
      logic [WB_DATA_W-1:0] word;
      fd = $fopen("tb/fetch_stimulus.txt", "r");
      if (fd == 0)
         return;
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok == "W") begin                 // Block contents
            n = $fscanf(fd, "%d", idx);
            for (int k = 0; k < BLK_WORDS; k++) begin
               n = $fscanf(fd, "%h", word);
               ld_adr.push_back(WB_ADR_W'(idx * BLK_WORDS + k));
               ld_dat.push_back(word);
            end
         end else if (tok == "C") begin        // Command and expected result
            n = $fscanf(fd, "%d %d %d %h", op, idx, den, word);
            cmd_op.push_back(op[0]);
            cmd_idx.push_back(BLK_IDX_W'(idx));
            cmd_den.push_back(2'(den));
            cmd_exp.push_back(word);
         end else begin
            n = $fgets(rest, fd);              // Comment line
         end
      end
      $fclose(fd);
   endtask

   // Memory fill through the load port, engine idle
   task automatic load_memory();
      for (int i = 0; i < ld_dat.size(); i++) begin
         @(negedge clk_i);
         load_we  = 1'b1;
         load_adr = ld_adr[i];
         load_dat = ld_dat[i];
      end
      @(negedge clk_i);
      load_we = 1'b0;
   endtask

   task automatic run_command(input logic op, input logic [BLK_IDX_W-1:0] idx,
                              input logic [1:0] den, input logic [WB_DATA_W-1:0] want);
      @(negedge clk_i);
      cmd_valid = 1'b1;
      cmd       = {op, idx};
      exp_push  = 1'b1;
      exp_val   = want;
      exp_lat   = (den == 2'd0) ? 8'(NO_STALL_LAT) : 8'd0;
      @(negedge clk_i);
      cmd_valid = 1'b0;
      exp_push  = 1'b0;
      draw_stall(den);
      repeat (2) begin
         @(negedge clk_i);
         draw_stall(den);
      end
      // Lands while busy, must be dropped
      cmd_valid = 1'b1;
      cmd       = {~op, BLK_IDX_W'(idx + 1'b1)};
      @(negedge clk_i);
      cmd_valid = 1'b0;
      draw_stall(den);
      while (!done) begin
         @(negedge clk_i);
         draw_stall(den);
      end
      stall = 1'b0;
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      int errs;
      rst_i     = 1'b1;
      cmd_valid = 1'b0;
      cmd       = '0;
      load_we   = 1'b0;
      load_adr  = '0;
      load_dat  = '0;
      stall     = 1'b0;
      exp_push  = 1'b0;
      exp_val   = '0;
      exp_lat   = '0;
      read_stimulus();
      if (ld_dat.size() == 0 || cmd_exp.size() == 0) begin
         $display("stimulus file tb/fetch_stimulus.txt missing or empty");
         $display("sim failed");
         $finish;
      end else begin
         limit = RST_CYCLES + ld_dat.size() + 4 + CMD_BUDGET * cmd_exp.size();
         repeat (RST_CYCLES) @(negedge clk_i);
         rst_i = 1'b0;
         load_memory();
         for (int i = 0; i < cmd_exp.size(); i++)
            run_command(cmd_op[i], cmd_idx[i], cmd_den[i], cmd_exp[i]);
         repeat (4) @(negedge clk_i);          // Room for a stray done_o
         errs = chk_err + fetch_top_i.burst_i.assertions_i.fail_cnt;
         $display("errors: %0d, results checked: %0d of %0d, missing: %0d",
                  errs, chk_cnt, cmd_exp.size(), pend);
         if (errs == 0 && pend == 0 && chk_cnt == cmd_exp.size())
            $display("sim passed");
         else
            $display("sim failed");
         $finish;
      end
   end

   // Watchdog
   always @(posedge clk_i) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout after %0d cycles, done_o never came for %0d command(s)",
                  cycles, pend);
         $display("errors: %0d, results checked: %0d", chk_err, chk_cnt);
         $display("sim failed");
         $finish;
      end
   end

endmodule

// File: tb/fetch_stimulus.txt
# W <block> <eight hex words from the lowest address up>
# C <op 0 sum 1 xor> <block> <stall density 0..3> <expected result hex>
W 0 0001 0002 0003 0004 0005 0006 0007 0008
W 1 1000 2000 3000 4000 5000 6000 7000 8000
W 2 ffff ffff ffff ffff ffff ffff ffff ffff
W 3 00ff 0f0f 3333 5555 aaaa cccc f0f0 ff00
W 4 1234 0000 0000 0000 0000 0000 0000 0001
C 0 0 0 0024
C 1 0 0 0008
C 0 1 0 4000
C 1 1 0 8000
C 0 2 1 fff8
C 1 2 2 0000
C 0 3 3 fffc
C 1 4 1 1235
C 0 0 2 0024
C 1 1 3 8000
C 0 3 0 fffc

// File: flist.f
rtl/wb_pkg.sv
rtl/blk_pkg.sv
rtl/fetch_decode.sv
rtl/fetch_burst.sv
rtl/wb_sram.sv
rtl/fetch_result.sv
rtl/fetch_top.sv
tb/fetch_assertions.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the block fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fetch_tb \
   -f flist.f -Mdir obj_dir -o Vfetch_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vfetch_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "sim passed" sim.log; then
   exit 0
fi
exit 1
